// File: tb.f
+incdir+include
rtl/rv32_isa_pkg.sv
rtl/dmem_bus_pkg.sv
rtl/dmem_access_align.sv
rtl/load_extender.sv
rtl/fence_flush_ctrl.sv
rtl/mem_stage.sv
bench/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rv32_isa_pkg.sv
      - rtl/dmem_bus_pkg.sv
      - rtl/dmem_access_align.sv
      - rtl/load_extender.sv
      - rtl/fence_flush_ctrl.sv
      - rtl/mem_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mem_stage_tb.sv

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module mem_stage_tb;

    import rv32_isa_pkg::*;
    import dmem_bus_pkg::*;

    localparam int FENCE_TIMEOUT = 20;

    logic CLK, nRST;
    logic valid, dren, dwen, reg_write, branch, jump, prediction, branch_taken;
    logic ifence, halt_insn, suppress_data, dbus_busy, iflush_done, dflush_done;
    load_type_e load_type;
    wsel_e w_sel;
    reg_idx_t rd, rd_m;
    word_t alu_out, rs2_data, pc4, imm_u, brj_addr, dbus_rdata, csr_rdata;
    logic dbus_ren, dbus_wen, icache_flush, dcache_flush, mem_busy, fence_stall;
    logic mal_load, mal_store, mispredict, pred_update, pred_taken, reg_write_m, fw_load, halt;
    byte_en_t dbus_byte_en;
    word_t dbus_addr, dbus_wdata, pred_addr, reg_wdata, fw_data;

    integer seed = 32'hed83f7e3;
    logic check_en;
    int unsigned i_wait, d_wait;
    load_type_e ld_types[6] = '{LB, LH, LW, LBU, LHU, NONE};
    wsel_e wb_sels[4] = '{W_PC4, W_IMM_U, W_ALU, W_CSR};

    mem_stage dut0 (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Each cache finishes its flush 1 to 6 cycles after the pulse
    always @(posedge CLK) begin : cache_model
        if (icache_flush) begin
            iflush_done <= 1'b0;
            i_wait <= 1 + {$random(seed)} % 6;
        end else if (i_wait > 0) begin
            i_wait <= i_wait - 1;
            iflush_done <= (i_wait == 1);
        end
        if (dcache_flush) begin
            dflush_done <= 1'b0;
            d_wait <= 1 + {$random(seed)} % 6;
        end else if (d_wait > 0) begin
            d_wait <= d_wait - 1;
            dflush_done <= (d_wait == 1);
        end
    end

    function automatic byte_en_t exp_byte_en(input logic rd_en, input load_type_e lt,
                                             input word_t addr);
        byte_en_t lanes;
        byte_en_t out;
        lanes = (lt == LW) ? 4'b1111 : 4'b0000;
        if (lt == LB || lt == LBU)
            lanes = 4'b0001 << addr[1:0];
        if ((lt == LH || lt == LHU) && !addr[0])
            lanes = 4'b0011 << addr[1:0];
        // Anything but a load leaves in reversed lane order on a little-endian bus
        for (int i = 0; i < 4; i++)
            out[i] = (`MEM_BUS_LITTLE_ENDIAN != 0 && !rd_en) ? lanes[3 - i] : lanes[i];
        return out;
    endfunction

    function automatic word_t exp_store_data(input logic wr_en, input load_type_e lt,
                                             input word_t rs2);
        int nbytes;
        word_t data;
        nbytes = (lt == LB) ? 1 : (lt == LH) ? 2 : (lt == LW) ? 4 : 0;
        data = '0;
        for (int i = 0; i < 4; i++)
            if (wr_en && nbytes != 0)
                data[8*i +: 8] = rs2[8*(i % nbytes) +: 8];
        return data;
    endfunction

    function automatic logic exp_misaligned(input load_type_e lt, input word_t addr);
        if (lt == LW)
            return addr[1:0] != 2'b00;
        if (lt == LH || lt == LHU)
            return addr[0];
        return 1'b0;
    endfunction

    function automatic word_t exp_load(input word_t rdata, input load_type_e lt,
                                       input byte_en_t be);
        int lane;
        word_t lo;
        logic byte_ok;
        logic half_ok;
        // Lowest enabled lane moves down to bit 0
        lane = 0;
        for (int i = 3; i >= 0; i--)
            if (be[i])
                lane = i;
        lo = rdata >> (8 * lane);
        byte_ok = (be == (4'b0001 << lane));
        half_ok = (be == 4'b0011) || (be == 4'b1100);
        case (lt)
            LB:      return byte_ok ? {{24{lo[7]}}, lo[7:0]} : '0;
            LBU:     return byte_ok ? {24'h000000, lo[7:0]} : '0;
            LH:      return half_ok ? {{16{lo[15]}}, lo[15:0]} : '0;
            LHU:     return half_ok ? {16'h0000, lo[15:0]} : '0;
            LW:      return rdata;
            default: return '0;
        endcase
    endfunction

    function automatic word_t exp_wdata(input wsel_e sel, input word_t ld, input word_t pc4_v,
                                        input word_t imm_v, input word_t alu_v,
                                        input word_t csr_v);
        case (sel)
            W_LOAD:  return ld;
            W_PC4:   return pc4_v;
            W_IMM_U: return imm_v;
            W_ALU:   return alu_v;
            W_CSR:   return csr_v;
            default: return '0;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp)
            abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    // Combinational outputs against the inputs of the cycle that is ending
    always @(posedge CLK) begin : compare_outputs
        byte_en_t be;
        word_t ld;
        if (check_en) begin
            be = exp_byte_en(dren, load_type, alu_out);
            ld = exp_load(dbus_rdata, load_type, be);
            check_byte_en("dbus_byte_en", dbus_byte_en, be);
            check_word("dbus_wdata", dbus_wdata, exp_store_data(dwen, load_type, rs2_data));
            check_word("dbus_addr", dbus_addr, alu_out);
            check_bit("dbus_ren", dbus_ren, dren & ~suppress_data);
            check_bit("dbus_wen", dbus_wen, dwen & ~suppress_data);
            check_bit("mem_busy", mem_busy, dbus_busy);
            check_bit("mal_load", mal_load, dren & exp_misaligned(load_type, alu_out));
            check_bit("mal_store", mal_store, dwen & exp_misaligned(load_type, alu_out));
            check_word("reg_wdata", reg_wdata,
                       exp_wdata(w_sel, ld, pc4, imm_u, alu_out, csr_rdata));
            check_word("fw_data", fw_data, exp_wdata(w_sel, '0, pc4, imm_u, alu_out, csr_rdata));
            check_bit("fw_load", fw_load, dren | dwen);
            check_bit("reg_write_m", reg_write_m, valid & reg_write);
            check_word("rd_m", word_t'(rd_m), word_t'(rd));
            check_bit("pred_update", pred_update, branch);
            check_bit("pred_taken", pred_taken, branch_taken);
            check_word("pred_addr", pred_addr, brj_addr);
            check_bit("mispredict", mispredict, branch & (prediction ^ branch_taken));
            check_bit("halt", halt, valid & halt_insn & ~jump);
        end
    end

    task automatic drive_slot(input logic rd_en, input logic wr_en, input load_type_e lt,
                              input wsel_e ws, input byte_off_t off);
        word_t addr;
        addr = $random(seed);
        @(posedge CLK);
        dren <= rd_en;
        dwen <= wr_en;
        load_type <= lt;
        w_sel <= ws;
        alu_out <= {addr[31:2], off};
        rs2_data <= $random(seed);
        dbus_rdata <= $random(seed);
        pc4 <= $random(seed);
        imm_u <= $random(seed);
        csr_rdata <= $random(seed);
        brj_addr <= $random(seed);
        rd <= $random(seed);
        // Suppressed on roughly one slot in four
        suppress_data <= ({$random(seed)} % 4) == 0;
        {valid, reg_write, branch, jump, prediction, branch_taken, halt_insn, dbus_busy}
            <= $random(seed);
    endtask

    task automatic run_fence();
        int cycles;
        logic i_pend;
        logic d_pend;
        logic stalled;
        @(posedge CLK);
        ifence <= 1'b1;
        @(posedge CLK);
        // First fence cycle carries the pulse while nothing is pending yet
        check_bit("icache_flush", icache_flush, 1'b1);
        check_bit("dcache_flush", dcache_flush, 1'b1);
        check_bit("fence_stall", fence_stall, 1'b0);
        i_pend = 1'b1;
        d_pend = 1'b1;
        stalled = 1'b1;
        cycles = 0;
        while (stalled) begin
            if (cycles == FENCE_TIMEOUT)
                abort_run("timeout waiting for fence_stall to fall after the cache flush");
            @(posedge CLK);
            check_bit("icache_flush", icache_flush, 1'b0);
            check_bit("dcache_flush", dcache_flush, 1'b0);
            check_bit("fence_stall", fence_stall, i_pend | d_pend);
            stalled = fence_stall;
            i_pend = i_pend & ~iflush_done;
            d_pend = d_pend & ~dflush_done;
            cycles++;
        end
        // A held fence must not pulse again
        repeat (3) begin
            @(posedge CLK);
            check_bit("icache_flush", icache_flush, 1'b0);
            check_bit("dcache_flush", dcache_flush, 1'b0);
            check_bit("fence_stall", fence_stall, 1'b0);
        end
        ifence <= 1'b0;
    endtask

    initial begin : stimulus
        nRST = 1'b0;
        {valid, dren, dwen, reg_write, branch, jump, prediction, branch_taken} = '0;
        {ifence, halt_insn, suppress_data, dbus_busy} = '0;
        {alu_out, rs2_data, pc4, imm_u, brj_addr, dbus_rdata, csr_rdata} = '0;
        load_type = NONE;
        w_sel = W_ALU;
        rd = '0;
        iflush_done = 1'b1;
        dflush_done = 1'b1;
        i_wait = 0;
        d_wait = 0;
        check_en = 1'b0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        check_bit("icache_flush", icache_flush, 1'b0);
        check_bit("dcache_flush", dcache_flush, 1'b0);
        check_bit("fence_stall", fence_stall, 1'b0);
        check_en <= 1'b1;
        repeat (200) drive_slot(1'b0, 1'b1, ld_types[{$random(seed)} % 3], W_ALU, $random(seed));
        repeat (200) drive_slot(1'b1, 1'b0, ld_types[{$random(seed)} % 5], W_LOAD, $random(seed));
        // Every access kind at every offset as load, store and no access
        for (int dir = 0; dir < 3; dir++)
            for (int t = 0; t < 6; t++)
                for (int off = 0; off < 4; off++)
                    drive_slot(dir == 1, dir == 2, ld_types[t], W_LOAD, off);
        foreach (wb_sels[s])
            repeat (20)
                drive_slot($random(seed), $random(seed), ld_types[s], wb_sels[s], $random(seed));
        run_fence();
        run_fence();
        @(posedge CLK);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                     CLK,
    input  logic                     nRST,

    // Access fields from the execute/memory register
    input  logic                     valid,
    input  logic                     dren,
    input  logic                     dwen,
    input  rv32_isa_pkg::load_type_e load_type,
    input  rv32_isa_pkg::word_t      alu_out,
    input  rv32_isa_pkg::word_t      rs2_data,

    // Writeback fields
    input  rv32_isa_pkg::wsel_e      w_sel,
    input  logic                     reg_write,
    input  rv32_isa_pkg::reg_idx_t   rd,
    input  rv32_isa_pkg::word_t      pc4,
    input  rv32_isa_pkg::word_t      imm_u,

    // Control fields
    input  logic                     branch,
    input  logic                     jump,
    input  logic                     prediction,
    input  logic                     branch_taken,
    input  rv32_isa_pkg::word_t      brj_addr,
    input  logic                     ifence,
    input  logic                     halt_insn,
    input  logic                     suppress_data,

    // Data bus, caches and CSR file
    input  rv32_isa_pkg::word_t      dbus_rdata,
    input  logic                     dbus_busy,
    input  logic                     iflush_done,
    input  logic                     dflush_done,
    input  rv32_isa_pkg::word_t      csr_rdata,

    output logic                     dbus_ren,
    output logic                     dbus_wen,
    output rv32_isa_pkg::word_t      dbus_addr,
    output dmem_bus_pkg::byte_en_t   dbus_byte_en,
    output rv32_isa_pkg::word_t      dbus_wdata,

    output logic                     icache_flush,
    output logic                     dcache_flush,

    // Hazard side
    output logic                     mem_busy,
    output logic                     fence_stall,
    output logic                     mal_load,
    output logic                     mal_store,
    output logic                     mispredict,

    // Branch predictor update
    output logic                     pred_update,
    output logic                     pred_taken,
    output rv32_isa_pkg::word_t      pred_addr,

    // Writeback and forwarding
    output rv32_isa_pkg::word_t      reg_wdata,
    output logic                     reg_write_m,
    output rv32_isa_pkg::reg_idx_t   rd_m,
    output rv32_isa_pkg::word_t      fw_data,
    output logic                     fw_load,

    output logic                     halt
);

    import rv32_isa_pkg::*;

    logic  misaligned;
    word_t load_data;

    dmem_access_align u_align (
        .dren       (dren),
        .dwen       (dwen),
        .load_type  (load_type),
        .addr       (alu_out),
        .rs2_data   (rs2_data),
        .byte_en    (dbus_byte_en),
        .store_data (dbus_wdata),
        .misaligned (misaligned)
    );

    load_extender u_ext (
        .rdata     (dbus_rdata),
        .load_type (load_type),
        .byte_en   (dbus_byte_en),
        .ext_data  (load_data)
    );

    fence_flush_ctrl u_fence (
        .CLK          (CLK),
        .nRST         (nRST),
        .ifence       (ifence),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .fence_stall  (fence_stall)
    );

    // Bus strobes drop while the hazard unit suppresses data access
    assign dbus_ren  = dren & ~suppress_data;
    assign dbus_wen  = dwen & ~suppress_data;
    assign dbus_addr = alu_out;
    assign mem_busy  = dbus_busy;

    assign mal_load  = dren & misaligned;
    assign mal_store = dwen & misaligned;

    // Predictor sees every resolved branch
    assign pred_update = branch;
    assign pred_taken  = branch_taken;
    assign pred_addr   = brj_addr;
    assign mispredict  = branch & (prediction ^ branch_taken);

    // Load data is not ready in time to forward from here
    always_comb begin
        case (w_sel)
            W_PC4:   fw_data = pc4;
            W_IMM_U: fw_data = imm_u;
            W_ALU:   fw_data = alu_out;
            W_CSR:   fw_data = csr_rdata;
            default: fw_data = '0;
        endcase
    end

    assign reg_wdata = (w_sel == W_LOAD) ? load_data : fw_data;

    // Bubbles never write a register
    assign reg_write_m = valid & reg_write;
    assign rd_m        = rd;
    assign fw_load     = dren | dwen;

    // Halt only retires from a valid slot that is not a jump
    assign halt = valid & halt_insn & ~jump;

endmodule

`default_nettype wire

// File: rtl/fence_flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fence_flush_ctrl (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic icache_flush,
    output logic dcache_flush,
    output logic fence_stall
);

    import dmem_bus_pkg::*;

    logic         ifence_q;
    logic         flush_pulse;
    flush_state_e istate;
    flush_state_e dstate;

    // A new flush wins over a done still left high from an earlier one
    function automatic flush_state_e next_state(input flush_state_e cur,
                                                input logic pulse,
                                                input logic done);
        flush_state_e nxt;
        if (pulse) begin
            nxt = FL_PENDING;
        end else if (done) begin
            nxt = FL_DONE;
        end else begin
            nxt = cur;
        end
        return nxt;
    endfunction

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_q <= 1'b0;
            istate   <= FL_DONE;
            dstate   <= FL_DONE;
        end else begin
            ifence_q <= ifence;
            istate   <= next_state(istate, flush_pulse, iflush_done);
            dstate   <= next_state(dstate, flush_pulse, dflush_done);
        end
    end

    // Both caches share one pulse on the rising edge of the fence
    assign flush_pulse  = ifence & ~ifence_q;
    assign icache_flush = flush_pulse;
    assign dcache_flush = flush_pulse;

    assign fence_stall = ifence & ((istate == FL_PENDING) | (dstate == FL_PENDING));

endmodule

`default_nettype wire

// File: rtl/load_extender.sv
`timescale 1ns/1ps
`default_nettype none

module load_extender (
    input  rv32_isa_pkg::word_t      rdata,
    input  rv32_isa_pkg::load_type_e load_type,
    input  dmem_bus_pkg::byte_en_t   byte_en,
    output rv32_isa_pkg::word_t      ext_data
);

    import rv32_isa_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Lane picked by a single-byte enable
    always_comb begin
        case (byte_en)
            4'b0001: byte_sel = rdata[7:0];
            4'b0010: byte_sel = rdata[15:8];
            4'b0100: byte_sel = rdata[23:16];
            4'b1000: byte_sel = rdata[31:24];
            default: byte_sel = 8'h00;
        endcase
    end

    // Halfword picked by a two-lane enable
    always_comb begin
        case (byte_en)
            4'b0011: half_sel = rdata[15:0];
            4'b1100: half_sel = rdata[31:16];
            default: half_sel = 16'h0000;
        endcase
    end

    always_comb begin
        case (load_type)
            LB:      ext_data = {{24{byte_sel[7]}}, byte_sel};
            LBU:     ext_data = {24'h000000, byte_sel};
            LH:      ext_data = {{16{half_sel[15]}}, half_sel};
            LHU:     ext_data = {16'h0000, half_sel};
            LW:      ext_data = rdata;
            default: ext_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/dmem_access_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module dmem_access_align (
    input  logic                     dren,
    input  logic                     dwen,
    input  rv32_isa_pkg::load_type_e load_type,
    input  rv32_isa_pkg::word_t      addr,
    input  rv32_isa_pkg::word_t      rs2_data,
    output dmem_bus_pkg::byte_en_t   byte_en,
    output rv32_isa_pkg::word_t      store_data,
    output logic                     misaligned
);

    import rv32_isa_pkg::*;
    import dmem_bus_pkg::*;

    byte_off_t offset;
    byte_en_t  lane_en;
    word_t     store_rep;

    assign offset = addr[1:0];

    // Lane enables in natural order with lane 0 at offset 0
    always_comb begin
        case (load_type)
            LB, LBU: begin
                case (offset)
                    2'b00:   lane_en = 4'b0001;
                    2'b01:   lane_en = 4'b0010;
                    2'b10:   lane_en = 4'b0100;
                    default: lane_en = 4'b1000;
                endcase
            end
            LH, LHU: begin
                case (offset)
                    2'b00:   lane_en = 4'b0011;
                    2'b10:   lane_en = 4'b1100;
                    default: lane_en = 4'b0000;
                endcase
            end
            LW:      lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
    end

    // Judged on the access itself before any lane reordering
    always_comb begin
        case (load_type)
            LW:      misaligned = (offset != 2'b00);
            LH, LHU: misaligned = offset[0];
            default: misaligned = 1'b0;
        endcase
    end

    // Replicate the store operand so every lane carries it
    always_comb begin
        case (load_type)
            LB:      store_rep = {4{rs2_data[7:0]}};
            LH:      store_rep = {2{rs2_data[15:0]}};
            LW:      store_rep = rs2_data;
            default: store_rep = '0;
        endcase
    end

    // Write data stays quiet unless a store is in the slot
    assign store_data = dwen ? store_rep : '0;

    generate
        if (`MEM_BUS_LITTLE_ENDIAN) begin : g_bus_le
            // Loads keep natural order on this bus
            assign byte_en = dren ? lane_en
                                  : {lane_en[0], lane_en[1], lane_en[2], lane_en[3]};
        end else begin : g_bus_be
            assign byte_en = lane_en;
        end
    endgenerate

endmodule

`default_nettype wire

// File: rtl/dmem_bus_pkg.sv
`default_nettype none

package dmem_bus_pkg;

    // One enable per byte lane of the data bus
    typedef logic [3:0] byte_en_t;

    // Low address bits that give the byte position inside a word
    typedef logic [1:0] byte_off_t;

    // Flush status of one cache
    // FL_PENDING from the flush pulse until the cache reports done
    typedef enum logic {
        FL_DONE    = 1'b0,
        FL_PENDING = 1'b1
    } flush_state_e;

endpackage

`default_nettype wire

// File: rtl/rv32_isa_pkg.sv
`default_nettype none

`include "mem_stage_config.svh"

package rv32_isa_pkg;

    // One data or address word
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // Destination register index
    typedef logic [4:0] reg_idx_t;

    // Access kind encoded as the RV32I funct3 of the load
    // Stores reuse LB, LH and LW for their width
    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        LBU  = 3'b100,
        LHU  = 3'b101,
        NONE = 3'b111
    } load_type_e;

    // Writeback source
    typedef enum logic [2:0] {
        W_LOAD  = 3'd0,
        W_PC4   = 3'd1,
        W_IMM_U = 3'd2,
        W_ALU   = 3'd3,
        W_CSR   = 3'd4
    } wsel_e;

endpackage

`default_nettype wire

// File: include/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Width of the data bus and of every register word
`define DATA_WIDTH 32

// Data bus byte order
// 1 selects a little-endian bus, so store byte enables leave the stage
// in reversed lane order. Set to 0 for a big-endian bus, where lanes
// pass through as generated.
// Load enables are never reversed.
`define MEM_BUS_LITTLE_ENDIAN 1

`endif
